/* source/cpuTypesPkg.sv */
package cpuTypesPkg;

	localparam int ADDRESS_WIDTH = 16;
	localparam int FLAG_COUNT = 4;

	// One program word per address
	typedef logic [ADDRESS_WIDTH-1:0] address_t;

	typedef logic [FLAG_COUNT-1:0] ccFlags_t;

	// Where the next program counter comes from
	typedef enum logic [2:0] {
		PC_NEXT = 3'd0,
		PC_INTV0 = 3'd1,
		PC_INTV1 = 3'd2,
		PC_INTR0 = 3'd3,
		PC_INTR1 = 3'd4
	} pcSelect_t;

	// Where the next flags come from
	typedef enum logic [1:0] {
		CC_ALU = 2'd0,
		CC_RESTORE0 = 2'd1,
		CC_RESTORE1 = 2'd2
	} ccSelect_t;

endpackage

/* source/intCtrlPkg.sv */
package intCtrlPkg;

	import cpuTypesPkg::*;

	// Phase of the interrupt sequence, advanced at each commit
	typedef enum logic [2:0] {
		RUN = 3'd0,
		VECTOR0 = 3'd1,
		VECTOR1 = 3'd2,
		RETURN0 = 3'd3,
		RETURN1 = 3'd4
	} intPhase_t;

	// Handler entry points
	localparam address_t INT0_VECTOR = 16'h0004;
	localparam address_t INT1_VECTOR = 16'h0008;

	localparam address_t RESET_ADDRESS = 16'h0000;

	typedef struct packed {
		pcSelect_t sel;
		logic save0;
		logic save1;
	} pcControl_t;

	typedef struct packed {
		ccSelect_t sel;
		logic save0;
		logic save1;
	} ccControl_t;

endpackage

/* source/interruptStateMachine.sv */
`timescale 1ns/100ps

module interruptStateMachine (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input logic retI,
	input logic enableInt,
	input logic disableInt,
	input logic int0,
	input logic int1,
	output intCtrlPkg::pcControl_t pcControl,
	output intCtrlPkg::ccControl_t ccControl
);

	import cpuTypesPkg::*;
	import intCtrlPkg::*;

	intPhase_t phase;
	intPhase_t nextPhase;

	logic inService0;
	logic inService1;
	logic nextInService0;
	logic nextInService1;

	logic intEnable;
	logic nextIntEnable;

	logic take0;
	logic take1;
	logic takeReturn;

	// Program counter control for a phase
	function automatic pcControl_t decodePc(input intPhase_t p);
		pcControl_t ctrl;
		ctrl.sel = PC_NEXT;
		ctrl.save0 = 1'b0;
		ctrl.save1 = 1'b0;
		case (p)
			VECTOR0: begin
				ctrl.sel = PC_INTV0;
				ctrl.save0 = 1'b1;
			end
			VECTOR1: begin
				ctrl.sel = PC_INTV1;
				ctrl.save1 = 1'b1;
			end
			RETURN0: ctrl.sel = PC_INTR0;
			RETURN1: ctrl.sel = PC_INTR1;
			default: ctrl.sel = PC_NEXT;
		endcase
		return ctrl;
	endfunction

	// Flag control for a phase
	function automatic ccControl_t decodeCc(input intPhase_t p);
		ccControl_t ctrl;
		ctrl.sel = CC_ALU;
		ctrl.save0 = 1'b0;
		ctrl.save1 = 1'b0;
		case (p)
			VECTOR0: ctrl.save0 = 1'b1;
			VECTOR1: ctrl.save1 = 1'b1;
			RETURN0: ctrl.sel = CC_RESTORE0;
			RETURN1: ctrl.sel = CC_RESTORE1;
			default: ctrl.sel = CC_ALU;
		endcase
		return ctrl;
	endfunction

	// NMI only blocked by itself
	assign take0 = int0 && !inService0;
	assign take1 = int1 && intEnable && !inService0 && !inService1;
	assign takeReturn = retI && (inService0 || inService1);

	always_comb begin
		nextPhase = RUN;
		nextInService0 = inService0;
		nextInService1 = inService1;
		case (phase)
			RUN: begin
				if (take0) begin
					nextPhase = VECTOR0;
					nextInService0 = 1'b1;
				end else if (take1) begin
					nextPhase = VECTOR1;
					nextInService1 = 1'b1;
				end else if (takeReturn) begin
					// Innermost level returns first
					if (inService0) begin
						nextPhase = RETURN0;
						nextInService0 = 1'b0;
					end else begin
						nextPhase = RETURN1;
						nextInService1 = 1'b0;
					end
				end
			end
			default: nextPhase = RUN;
		endcase
	end

	always_comb begin
		nextIntEnable = intEnable;
		if (enableInt) begin
			nextIntEnable = 1'b1;
		end
		// Disable wins over a simultaneous enable
		if (disableInt) begin
			nextIntEnable = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= RUN;
			inService0 <= 1'b0;
			inService1 <= 1'b0;
			intEnable <= 1'b0;
		end else if (commit) begin
			phase <= nextPhase;
			inService0 <= nextInService0;
			inService1 <= nextInService1;
			intEnable <= nextIntEnable;
		end
	end

	// Registered controls, held between commits
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pcControl <= decodePc(RUN);
			ccControl <= decodeCc(RUN);
		end else if (commit) begin
			pcControl <= decodePc(nextPhase);
			ccControl <= decodeCc(nextPhase);
		end
	end

endmodule

/* source/programCounterUnit.sv */
`timescale 1ns/100ps

module programCounterUnit (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input intCtrlPkg::pcControl_t pcControl,
	output cpuTypesPkg::address_t pc
);

	import cpuTypesPkg::*;
	import intCtrlPkg::*;

	// Return addresses, one per interrupt level
	address_t returnAddress0;
	address_t returnAddress1;

	address_t nextPc;

	always_comb begin
		case (pcControl.sel)
			PC_NEXT: nextPc = pc + address_t'(1);
			PC_INTV0: nextPc = INT0_VECTOR;
			PC_INTV1: nextPc = INT1_VECTOR;
			PC_INTR0: nextPc = returnAddress0;
			PC_INTR1: nextPc = returnAddress1;
			default: nextPc = pc + address_t'(1);
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= RESET_ADDRESS;
		end else if (commit) begin
			pc <= nextPc;
		end
	end

	// Save the interrupted address on entry
	always_ff @(posedge CLK) begin
		if (commit && pcControl.save0) begin
			returnAddress0 <= pc;
		end
		if (commit && pcControl.save1) begin
			returnAddress1 <= pc;
		end
	end

endmodule

/* source/conditionCodeUnit.sv */
`timescale 1ns/100ps

module conditionCodeUnit (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input logic flagWrite,
	input cpuTypesPkg::ccFlags_t aluFlags,
	input intCtrlPkg::ccControl_t ccControl,
	output cpuTypesPkg::ccFlags_t flags
);

	import cpuTypesPkg::*;
	import intCtrlPkg::*;

	// Flags as they were when each level was entered
	ccFlags_t savedFlags0;
	ccFlags_t savedFlags1;

	ccFlags_t nextFlags;

	always_comb begin
		case (ccControl.sel)
			CC_ALU: nextFlags = flagWrite ? aluFlags : flags;
			CC_RESTORE0: nextFlags = savedFlags0;
			CC_RESTORE1: nextFlags = savedFlags1;
			default: nextFlags = flags;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			flags <= '0;
		end else if (commit) begin
			flags <= nextFlags;
		end
	end

	// Copy taken before any ALU update in the same commit
	always_ff @(posedge CLK) begin
		if (commit && ccControl.save0) begin
			savedFlags0 <= flags;
		end
		if (commit && ccControl.save1) begin
			savedFlags1 <= flags;
		end
	end

endmodule

/* source/interruptController.sv */
`timescale 1ns/100ps

module interruptController (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input logic retI,
	input logic enableInt,
	input logic disableInt,
	input logic int0,
	input logic int1,
	input cpuTypesPkg::ccFlags_t aluFlags,
	input logic flagWrite,
	output cpuTypesPkg::address_t pc,
	output cpuTypesPkg::ccFlags_t flags,
	output cpuTypesPkg::pcSelect_t pcSelect
);

	import intCtrlPkg::*;

	pcControl_t pcControl;
	ccControl_t ccControl;

	interruptStateMachine i_interruptStateMachine (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.retI(retI),
		.enableInt(enableInt),
		.disableInt(disableInt),
		.int0(int0),
		.int1(int1),
		.pcControl(pcControl),
		.ccControl(ccControl)
	);

	programCounterUnit i_programCounterUnit (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.pcControl(pcControl),
		.pc(pc)
	);

	conditionCodeUnit i_conditionCodeUnit (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.flagWrite(flagWrite),
		.aluFlags(aluFlags),
		.ccControl(ccControl),
		.flags(flags)
	);

	// Decision visible outside
	assign pcSelect = pcControl.sel;

endmodule

/* tb/clockGen.sv */
`timescale 1ns/100ps

module clockGen (
	output logic CLK,
	output logic rstN
);

	// 100 ns period
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		rstN = 1'b0;
		repeat (10) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

/* tb/interruptController_properties.sv */
`timescale 1ns/100ps

module interruptController_properties (
	input logic CLK,
	input logic rstN,
	input logic commit,
	input cpuTypesPkg::address_t pc,
	input cpuTypesPkg::pcSelect_t pcSelect
);

	import cpuTypesPkg::*;

	// Sequencing right after reset
	assert property (@(posedge CLK) !rstN |=> pcSelect == PC_NEXT)
		else $error("pcSelect is not PC_NEXT after reset");

	assert property (@(posedge CLK) disable iff (!rstN)
		$changed(pc) |-> ($past(commit) || !$past(rstN)))
		else $error("pc changed without a commit");

	// Held between commits
	assert property (@(posedge CLK) disable iff (!rstN) !commit |=> $stable(pc))
		else $error("pc moved while commit was low");

endmodule

bind interruptController interruptController_properties i_properties (
	.CLK(CLK),
	.rstN(rstN),
	.commit(commit),
	.pc(pc),
	.pcSelect(pcSelect)
);

/* tb/interruptControllerTb.sv */
`timescale 1ns/100ps

module interruptControllerTb;

	import cpuTypesPkg::*;
	import intCtrlPkg::*;

	localparam int TEST_COUNT = 5;

	logic CLK;
	logic rstN;
	logic commit;
	logic retI;
	logic enableInt;
	logic disableInt;
	logic int0;
	logic int1;
	ccFlags_t aluFlags;
	logic flagWrite;
	address_t pc;
	ccFlags_t flags;
	pcSelect_t pcSelect;

	logic [7:0] lfsrState;
	ccFlags_t drawn;
	logic writeFlags;
	address_t expPc;
	int errorCount;
	int testErrors;
	int testsRun;
	int testsFailed;

	clockGen i_clockGen (.CLK(CLK), .rstN(rstN));

	interruptController i_dut (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.retI(retI),
		.enableInt(enableInt),
		.disableInt(disableInt),
		.int0(int0),
		.int1(int1),
		.aluFlags(aluFlags),
		.flagWrite(flagWrite),
		.pc(pc),
		.flags(flags),
		.pcSelect(pcSelect)
	);

	// Galois LFSR, 8 bits, taps 0xB8
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic checkAddr(input string name, input address_t expected, input address_t actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkFlags(input string name, input ccFlags_t expected, input ccFlags_t actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkSel(input string name, input pcSelect_t expected,
			input pcSelect_t actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %s, actual %s", name, expected.name(),
				actual.name());
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, testErrors);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	// One committed instruction, outputs sampled at the following negedge
	task automatic commitStep(input logic r, input logic en, input logic dis,
			input logic i0, input logic i1);
		ccFlags_t value;
		for (int b = 0; b < $bits(ccFlags_t); b++) begin
			value[b] = lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
		end
		@(posedge CLK);
		commit <= 1'b1;
		retI <= r;
		enableInt <= en;
		disableInt <= dis;
		int0 <= i0;
		int1 <= i1;
		aluFlags <= value;
		flagWrite <= writeFlags;
		drawn = value;
		@(posedge CLK);
		commit <= 1'b0;
		retI <= 1'b0;
		enableInt <= 1'b0;
		disableInt <= 1'b0;
		int0 <= 1'b0;
		int1 <= 1'b0;
		@(negedge CLK);
	endtask

	task automatic testSequencing();
		ccFlags_t expFlags;
		checkAddr("sequencing", RESET_ADDRESS, pc);
		checkSel("sequencing", PC_NEXT, pcSelect);
		expPc = RESET_ADDRESS;
		expFlags = '0;
		for (int i = 0; i < 4; i++) begin
			// Second instruction leaves the flags alone
			writeFlags = (i != 1);
			commitStep(0, 0, 0, 0, 0);
			expPc++;
			if (writeFlags) begin
				expFlags = drawn;
			end
			checkAddr("sequencing", expPc, pc);
			checkFlags("sequencing", expFlags, flags);
		end
		writeFlags = 1'b1;
		endTest("sequencing");
	endtask

	task automatic testNmi();
		address_t savedPc;
		ccFlags_t savedFlags;
		// Taken although interrupts are still disabled
		commitStep(0, 0, 0, 1, 0);
		expPc++;
		checkSel("nmi", PC_INTV0, pcSelect);
		savedPc = expPc;
		savedFlags = drawn;
		// Enabled inside the handler, int1 still held off
		commitStep(0, 1, 0, 0, 0);
		checkAddr("nmi", INT0_VECTOR, pc);
		commitStep(0, 0, 0, 1, 1);
		checkSel("nmi", PC_NEXT, pcSelect);
		checkAddr("nmi", INT0_VECTOR + address_t'(1), pc);
		commitStep(1, 0, 1, 0, 0);
		checkSel("nmi", PC_INTR0, pcSelect);
		commitStep(0, 0, 0, 0, 0);
		checkAddr("nmi", savedPc, pc);
		checkFlags("nmi", savedFlags, flags);
		expPc = savedPc;
		endTest("nmi");
	endtask

	task automatic testMasking();
		address_t savedPc;
		commitStep(0, 0, 0, 0, 1);
		expPc++;
		checkSel("masking", PC_NEXT, pcSelect);
		checkAddr("masking", expPc, pc);
		commitStep(0, 1, 0, 0, 0);
		expPc++;
		commitStep(0, 0, 0, 0, 1);
		expPc++;
		checkSel("masking", PC_INTV1, pcSelect);
		savedPc = expPc;
		commitStep(0, 0, 0, 0, 0);
		checkAddr("masking", INT1_VECTOR, pc);
		commitStep(1, 0, 1, 0, 0);
		checkSel("masking", PC_INTR1, pcSelect);
		commitStep(0, 0, 0, 0, 0);
		checkAddr("masking", savedPc, pc);
		expPc = savedPc;
		commitStep(0, 0, 0, 0, 1);
		expPc++;
		checkSel("masking", PC_NEXT, pcSelect);
		checkAddr("masking", expPc, pc);
		endTest("masking");
	endtask

	task automatic testNesting();
		address_t pc0;
		address_t pc1;
		ccFlags_t flags0;
		ccFlags_t flags1;
		commitStep(0, 1, 0, 0, 0);
		expPc++;
		commitStep(0, 0, 0, 0, 1);
		expPc++;
		checkSel("nesting", PC_INTV1, pcSelect);
		pc1 = expPc;
		flags1 = drawn;
		commitStep(0, 0, 0, 0, 0);
		checkAddr("nesting", INT1_VECTOR, pc);
		// NMI inside the int1 handler
		commitStep(0, 0, 0, 1, 0);
		checkSel("nesting", PC_INTV0, pcSelect);
		pc0 = INT1_VECTOR + address_t'(1);
		flags0 = drawn;
		commitStep(0, 0, 0, 0, 0);
		checkAddr("nesting", INT0_VECTOR, pc);
		commitStep(1, 0, 0, 0, 0);
		checkSel("nesting", PC_INTR0, pcSelect);
		commitStep(0, 0, 0, 0, 0);
		checkAddr("nesting", pc0, pc);
		checkFlags("nesting", flags0, flags);
		commitStep(1, 0, 0, 0, 0);
		checkSel("nesting", PC_INTR1, pcSelect);
		commitStep(0, 0, 0, 0, 0);
		checkAddr("nesting", pc1, pc);
		checkFlags("nesting", flags1, flags);
		expPc = pc1;
		commitStep(0, 0, 1, 0, 0);
		expPc++;
		endTest("nesting");
	endtask

	task automatic testSpuriousReturn();
		commitStep(1, 0, 0, 0, 0);
		expPc++;
		checkSel("spurious return", PC_NEXT, pcSelect);
		checkAddr("spurious return", expPc, pc);
		commitStep(0, 0, 0, 0, 0);
		expPc++;
		checkAddr("spurious return", expPc, pc);
		endTest("spurious return");
	endtask

	initial begin
		#(TEST_COUNT * 40 * 100);
		$display("Watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

	initial begin
		commit = 1'b0;
		retI = 1'b0;
		enableInt = 1'b0;
		disableInt = 1'b0;
		int0 = 1'b0;
		int1 = 1'b0;
		aluFlags = '0;
		flagWrite = 1'b0;
		writeFlags = 1'b1;
		lfsrState = 8'd62;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		wait (rstN === 1'b1);
		@(negedge CLK);
		testSequencing();
		testNmi();
		testMasking();
		testNesting();
		testSpuriousReturn();
		$display("Tests run %0d, failed %0d, failed checks %0d", testsRun, testsFailed,
			errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* sources.f */
source/cpuTypesPkg.sv
source/intCtrlPkg.sv
source/interruptStateMachine.sv
source/programCounterUnit.sv
source/conditionCodeUnit.sv
source/interruptController.sv
tb/clockGen.sv
tb/interruptController_properties.sv
tb/interruptControllerTb.sv

/* Bender.yml */
package:
  name: interrupt_controller

sources:
  - source/cpuTypesPkg.sv
  - source/intCtrlPkg.sv
  - source/interruptStateMachine.sv
  - source/programCounterUnit.sv
  - source/conditionCodeUnit.sv
  - source/interruptController.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/interruptController_properties.sv
      - tb/interruptControllerTb.sv
